//--- common/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int NWAY        = 2;
    localparam int NSET        = 256;
    localparam int INDEX_W     = 8;    // addr[11:4]
    localparam int TAG_W       = 20;   // addr[31:12]
    localparam int LINE_W      = 128;  // 16 bytes per line
    localparam int TAG_ENTRY_W = 21;   // {valid, tag}

    // bus request types
    localparam logic [2:0] TYPE_WORD = 3'b010;
    localparam logic [2:0] TYPE_LINE = 3'b100;

    // one cache line, seen as words for reads and as bytes for strobed writes
    typedef union packed {
        logic [3:0][31:0] words;
        logic [15:0][7:0] bytes;
    } cache_line_u;

endpackage

//--- rtl/bram.sv
`timescale 1ns/1ns

module bram #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                          clk,
    input  logic                          en,
    input  logic                          we,
    input  logic [dcache_pkg::INDEX_W-1:0] addr,
    input  logic [DATA_WIDTH-1:0]         wdata,
    output logic [DATA_WIDTH-1:0]         rdata
);

    import dcache_pkg::*;

    logic [DATA_WIDTH-1:0] mem [NSET];  // one entry per set

    // read-first: rdata shows the old entry on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

//--- rtl/lfsr.sv
`timescale 1ns/1ns

module lfsr (
    input  logic       clk,
    input  logic       rst,
    output logic [7:0] value
);

    logic feedback;

    // x^8 + x^6 + x^5 + x^4 + 1, period 255
    assign feedback = value[7] ^ value[5] ^ value[4] ^ value[3];

    always_ff @(posedge clk) begin
        if (rst) begin
            value <= 8'hb5;  // any nonzero seed
        end else begin
            value <= {value[6:0], feedback};
        end
    end

endmodule

//--- rtl/dcache/dcache_way.sv
`timescale 1ns/1ns

module dcache_way (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic                           fill,
    input  logic                           update,
    input  logic [dcache_pkg::TAG_W-1:0]   fill_tag,
    input  dcache_pkg::cache_line_u        fill_line,
    input  logic [3:0]                     upd_wstrb,
    input  logic [31:0]                    upd_word,
    input  logic [1:0]                     upd_offset,
    input  logic                           clear,
    output logic                           hit,
    output logic                           valid,
    output dcache_pkg::cache_line_u        line
);

    import dcache_pkg::*;

    logic [TAG_ENTRY_W-1:0] tag_rdata;
    logic [TAG_ENTRY_W-1:0] tag_wdata;
    logic [LINE_W-1:0]      data_rdata;
    logic [LINE_W-1:0]      data_wdata;
    cache_line_u            merged;

    assign tag_wdata = clear ? '0 : {1'b1, fill_tag};  // sweep writes invalid entries

    bram #(
        .DATA_WIDTH(TAG_ENTRY_W)
    ) u_tag_ram (
        .clk  (clk),
        .en   (1'b1),
        .we   (fill | clear),
        .addr (index),
        .wdata(tag_wdata),
        .rdata(tag_rdata)
    );

    bram #(
        .DATA_WIDTH(LINE_W)
    ) u_data_ram (
        .clk  (clk),
        .en   (!clear),  // data untouched during the sweep
        .we   (fill | update),
        .addr (index),
        .wdata(data_wdata),
        .rdata(data_rdata)
    );

    assign line  = data_rdata;
    assign valid = tag_rdata[TAG_ENTRY_W-1];
    assign hit   = valid && (tag_rdata[TAG_W-1:0] == fill_tag);  // fill_tag is the request tag

    // strobed bytes of the store land in the selected word of the held line
    always_comb begin
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (upd_wstrb[b]) begin
                merged.bytes[upd_offset * 4 + b] = upd_word[8 * b +: 8];
            end
        end
    end

    assign data_wdata = fill ? fill_line : merged;

    fill_update_excl: assert property (
        @(posedge clk) disable iff (rst) !(fill && update)
    );

endmodule

//--- rtl/dcache/dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl (
    input  logic                                       clk,
    input  logic                                       rst,
    input  logic                                       valid,
    input  logic                                       op,
    input  logic                                       uncache,
    input  logic [dcache_pkg::INDEX_W-1:0]             index,
    input  logic [dcache_pkg::TAG_W-1:0]               tag,
    input  logic [3:0]                                 offset,
    input  logic [3:0]                                 wstrb,
    input  logic [31:0]                                wdata,
    input  logic                                       flush_i,
    output logic                                       addr_ok,
    output logic                                       data_ok,
    output logic [31:0]                                rdata,
    output logic                                       rd_req,
    output logic [2:0]                                 rd_type,
    output logic [31:0]                                rd_addr,
    input  logic                                       rd_rdy,
    input  logic                                       ret_valid,
    input  logic                                       ret_last,
    input  logic [dcache_pkg::LINE_W-1:0]              ret_data,
    output logic                                       wr_req,
    output logic [2:0]                                 wr_type,
    output logic [31:0]                                wr_addr,
    output logic [15:0]                                wr_wstrb,
    output logic [dcache_pkg::LINE_W-1:0]              wr_data,
    input  logic                                       wr_rdy,
    output logic [dcache_pkg::INDEX_W-1:0]             way_index,
    output logic [dcache_pkg::TAG_W-1:0]               way_tag,
    output logic                                       way_clear,
    output logic [dcache_pkg::NWAY-1:0]                way_fill,
    output logic [dcache_pkg::NWAY-1:0]                way_update,
    output dcache_pkg::cache_line_u                    fill_line,
    output logic [3:0]                                 upd_wstrb,
    output logic [31:0]                                upd_word,
    output logic [1:0]                                 upd_offset,
    input  logic [dcache_pkg::NWAY-1:0]                way_hit,
    input  logic [dcache_pkg::NWAY-1:0]                way_valid,
    input  dcache_pkg::cache_line_u [dcache_pkg::NWAY-1:0] way_line,
    input  logic                                       rand_bit
);

    import dcache_pkg::*;

    typedef enum logic [2:0] {
        INIT,
        IDLE,
        LOOKUP,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ
    } state_t;

    state_t state;
    state_t next_state;

    logic [INDEX_W-1:0] init_cnt;
    logic               req_op;
    logic               req_uncache;
    logic [INDEX_W-1:0] req_index;
    logic [TAG_W-1:0]   req_tag;
    logic [3:0]         req_offset;
    logic [3:0]         req_wstrb;
    logic [31:0]        req_wdata;
    logic [1:0]         word_sel;
    logic [NWAY-1:0]    free_ways;
    logic [NWAY-1:0]    victim;
    logic [NWAY-1:0]    victim_q;
    logic               read_hit;
    logic               refill_done;
    logic               write_done;
    cache_line_u        hit_line;
    cache_line_u        ret_line;

    assign word_sel    = req_offset[3:2];
    assign read_hit    = !req_op && !req_uncache && (|way_hit);
    assign refill_done = (state == READ_WAIT) && ret_valid && ret_last;  // single beat
    assign write_done  = (state == WRITE_REQ) && wr_rdy && !flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT;
            init_cnt <= '0;
        end else begin
            state <= next_state;
            if (state == INIT) begin
                init_cnt <= init_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            INIT:      if (init_cnt == INDEX_W'(NSET - 1)) next_state = IDLE;
            IDLE:      if (valid) next_state = LOOKUP;
            LOOKUP: begin
                if (req_op) begin
                    next_state = WRITE_REQ;
                end else if (read_hit) begin
                    next_state = IDLE;
                end else begin
                    next_state = READ_REQ;  // miss or uncached
                end
            end
            READ_REQ:  if (rd_rdy) next_state = READ_WAIT;
            READ_WAIT: if (ret_valid && ret_last) next_state = IDLE;
            WRITE_REQ: if (wr_rdy || flush_i) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // request fields held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == IDLE && valid) begin
            req_op      <= op;
            req_uncache <= uncache;
            req_index   <= index;
            req_tag     <= tag;
            req_offset  <= offset;
            req_wstrb   <= wstrb;
            req_wdata   <= wdata;
        end
        if (state == LOOKUP) begin
            victim_q <= victim;
        end
    end

    // lowest invalid way first, random way when the set is full
    assign free_ways = ~way_valid;
    assign victim    = (|free_ways) ? (free_ways & (~free_ways + 1'b1))
                                    : (NWAY'(1) << rand_bit);

    assign way_index = (state == INIT) ? init_cnt :
                       (state == IDLE) ? index : req_index;  // read issued on acceptance
    assign way_tag    = req_tag;
    assign way_clear  = (state == INIT);
    assign way_fill   = {NWAY{refill_done && !req_uncache}} & victim_q;
    assign way_update = {NWAY{write_done}} & way_hit;  // write hit only, no allocate
    assign fill_line  = ret_data;
    assign upd_wstrb  = req_wstrb;
    assign upd_word   = req_wdata;
    assign upd_offset = word_sel;

    assign addr_ok = (state == IDLE);
    assign data_ok = ((state == LOOKUP) && read_hit) || refill_done || write_done;

    always_comb begin
        hit_line = '0;
        for (int i = 0; i < NWAY; i++) begin
            if (way_hit[i]) begin
                hit_line = way_line[i];
            end
        end
        ret_line = ret_data;
        if (state == READ_WAIT) begin
            rdata = req_uncache ? ret_data[31:0] : ret_line.words[word_sel];
        end else begin
            rdata = hit_line.words[word_sel];
        end
    end

    assign rd_req  = (state == READ_REQ);
    assign rd_type = req_uncache ? TYPE_WORD : TYPE_LINE;
    assign rd_addr = req_uncache ? {req_tag, req_index, word_sel, 2'b00}
                                 : {req_tag, req_index, 4'b0000};  // line aligned

    assign wr_req   = (state == WRITE_REQ) && !flush_i;  // flush drops the request
    assign wr_type  = TYPE_WORD;
    assign wr_addr  = {req_tag, req_index, word_sel, 2'b00};
    assign wr_wstrb = {12'b0, req_wstrb} << {word_sel, 2'b00};
    assign wr_data  = {96'b0, req_wdata} << {word_sel, 5'b00000};

    bus_req_excl: assert property (
        @(posedge clk) disable iff (rst) !(rd_req && wr_req)
    );

    no_resp_in_idle: assert property (
        @(posedge clk) disable iff (rst) (state == IDLE) |-> !data_ok
    );

    // a line never lives in both ways of a set
    single_way_hit: assert property (
        @(posedge clk) disable iff (rst)
        (state inside {LOOKUP, WRITE_REQ}) |-> $onehot0(way_hit)
    );

endmodule

//--- rtl/dcache/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           valid,
    input  logic                           op,       // 1 write, 0 read
    input  logic                           uncache,
    input  logic [dcache_pkg::INDEX_W-1:0] index,
    input  logic [dcache_pkg::TAG_W-1:0]   tag,
    input  logic [3:0]                     offset,
    input  logic [3:0]                     wstrb,
    input  logic [31:0]                    wdata,
    input  logic                           flush_i,  // cancels a pending write
    output logic                           addr_ok,
    output logic                           data_ok,
    output logic [31:0]                    rdata,
    output logic                           rd_req,
    output logic [2:0]                     rd_type,
    output logic [31:0]                    rd_addr,
    input  logic                           rd_rdy,
    input  logic                           ret_valid,
    input  logic                           ret_last,
    input  logic [dcache_pkg::LINE_W-1:0]  ret_data,
    output logic                           wr_req,
    output logic [2:0]                     wr_type,
    output logic [31:0]                    wr_addr,
    output logic [15:0]                    wr_wstrb,
    output logic [dcache_pkg::LINE_W-1:0]  wr_data,
    input  logic                           wr_rdy
);

    import dcache_pkg::*;

    logic [INDEX_W-1:0]     way_index;
    logic [TAG_W-1:0]       way_tag;
    logic                   way_clear;
    logic [NWAY-1:0]        way_fill;
    logic [NWAY-1:0]        way_update;
    cache_line_u            fill_line;
    logic [3:0]             upd_wstrb;
    logic [31:0]            upd_word;
    logic [1:0]             upd_offset;
    logic [NWAY-1:0]        way_hit;
    logic [NWAY-1:0]        way_valid;
    cache_line_u [NWAY-1:0] way_line;
    logic [7:0]             rand_value;

    dcache_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .valid     (valid),
        .op        (op),
        .uncache   (uncache),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .flush_i   (flush_i),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_type   (rd_type),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_type   (wr_type),
        .wr_addr   (wr_addr),
        .wr_wstrb  (wr_wstrb),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy),
        .way_index (way_index),
        .way_tag   (way_tag),
        .way_clear (way_clear),
        .way_fill  (way_fill),
        .way_update(way_update),
        .fill_line (fill_line),
        .upd_wstrb (upd_wstrb),
        .upd_word  (upd_word),
        .upd_offset(upd_offset),
        .way_hit   (way_hit),
        .way_valid (way_valid),
        .way_line  (way_line),
        .rand_bit  (rand_value[0])
    );

    for (genvar i = 0; i < NWAY; i++) begin : g_way
        dcache_way u_way (
            .clk       (clk),
            .rst       (rst),
            .index     (way_index),
            .fill      (way_fill[i]),
            .update    (way_update[i]),
            .fill_tag  (way_tag),
            .fill_line (fill_line),
            .upd_wstrb (upd_wstrb),
            .upd_word  (upd_word),
            .upd_offset(upd_offset),
            .clear     (way_clear),
            .hit       (way_hit[i]),
            .valid     (way_valid[i]),
            .line      (way_line[i])
        );
    end

    lfsr u_lfsr (
        .clk  (clk),
        .rst  (rst),
        .value(rand_value)
    );

endmodule

//--- verification/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          data_ok,
    input  logic [31:0]                   rdata,
    input  logic                          rd_req,
    input  logic [2:0]                    rd_type,
    input  logic [31:0]                   rd_addr,
    input  logic                          rd_rdy,
    input  logic                          wr_req,
    input  logic [2:0]                    wr_type,
    input  logic [31:0]                   wr_addr,
    input  logic [15:0]                   wr_wstrb,
    input  logic [dcache_pkg::LINE_W-1:0] wr_data,
    input  logic                          wr_rdy,
    input  logic                          req_op,       // current request from the testbench
    input  logic                          req_uncache,
    input  logic [31:0]                   req_addr,
    input  logic [3:0]                    req_wstrb,
    input  logic [31:0]                   req_wdata,
    input  logic [31:0]                   exp_word,
    output int                            errors,
    output int                            rd_fires,
    output int                            wr_fires
);

    import dcache_pkg::*;

    logic [31:0] exp_rd_addr;
    logic [2:0]  exp_rd_type;
    logic [15:0] exp_wstrb;
    logic [LINE_W-1:0] exp_wdata;

    // expected bus request for the current request
    assign exp_rd_type = req_uncache ? TYPE_WORD : TYPE_LINE;
    assign exp_rd_addr = req_uncache ? {req_addr[31:2], 2'b00} : {req_addr[31:4], 4'b0000};
    assign exp_wstrb   = {12'b0, req_wstrb} << (req_addr[3:2] * 4);
    assign exp_wdata   = {96'b0, req_wdata} << (req_addr[3:2] * 32);

    initial begin
        errors   = 0;
        rd_fires = 0;
        wr_fires = 0;
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (data_ok && !req_op && rdata !== exp_word) begin
                $display("error at %0t: rdata %h for addr %h, expected %h",
                         $time, rdata, req_addr, exp_word);
                errors++;
            end
            if (rd_req && rd_rdy) begin
                rd_fires++;
                if (rd_type !== exp_rd_type || rd_addr !== exp_rd_addr) begin
                    $display("error at %0t: read request type %b addr %h, expected %b %h",
                             $time, rd_type, rd_addr, exp_rd_type, exp_rd_addr);
                    errors++;
                end
            end
            if (wr_req && wr_rdy) begin
                wr_fires++;
                if (wr_type !== TYPE_WORD || wr_addr !== {req_addr[31:2], 2'b00}
                        || wr_wstrb !== exp_wstrb || wr_data !== exp_wdata) begin
                    $display("error at %0t: write request type %b addr %h strb %h data %h",
                             $time, wr_type, wr_addr, wr_wstrb, wr_data);
                    errors++;
                end
            end
        end
    end

endmodule

//--- verification/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

    import dcache_pkg::*;

    localparam int MEM_DEPTH = 16384;  // addr[15:2], tags kept below 16
    localparam int N_RAND    = 200;
    localparam int N_REQ     = N_RAND + 16;
    localparam longint LIMIT = (longint'(N_REQ) * 64 + 256 + 8) * 100;

    logic clk, rst, valid, op, uncache, flush_i;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    logic [3:0] offset, wstrb;
    logic [31:0] wdata, rdata, rd_addr, wr_addr;
    logic addr_ok, data_ok, rd_req, rd_rdy, ret_valid, ret_last, wr_req, wr_rdy;
    logic [2:0] rd_type, wr_type;
    logic [LINE_W-1:0] ret_data, wr_data;
    logic [15:0] wr_wstrb;
    logic [31:0] mem [MEM_DEPTH];
    logic [31:0] shadow [MEM_DEPTH];
    logic cur_op, cur_uncache, wr_block;
    logic [31:0] cur_addr, cur_wdata, exp_word;
    logic [3:0] cur_wstrb;
    int chk_errors, rd_fires, wr_fires, tb_errors, tests_failed;

    dcache_top UUT (.*);

    dcache_checker u_checker (
        .clk(clk), .rst(rst), .data_ok(data_ok), .rdata(rdata),
        .rd_req(rd_req), .rd_type(rd_type), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .wr_req(wr_req), .wr_type(wr_type), .wr_addr(wr_addr), .wr_wstrb(wr_wstrb),
        .wr_data(wr_data), .wr_rdy(wr_rdy), .req_op(cur_op), .req_uncache(cur_uncache),
        .req_addr(cur_addr), .req_wstrb(cur_wstrb), .req_wdata(cur_wdata),
        .exp_word(exp_word), .errors(chk_errors), .rd_fires(rd_fires), .wr_fires(wr_fires)
    );

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return shadow[addr[15:2]];
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(LIMIT);
        $display("watchdog expired, the DUT stopped answering requests");
        $display("STATUS: FAIL");
        $finish;
    end

    // bus memory model, decides at the falling edge and drives after the rising edge
    initial begin
        logic fire_rd, fire_wr, pend;
        logic [31:0] raddr;
        logic [2:0] rtype;
        int delay, lane;
        pend = 1'b0;
        delay = 0;
        forever begin
            @(negedge clk);
            fire_rd = rd_req && rd_rdy;
            fire_wr = wr_req && wr_rdy;
            if (fire_rd) begin
                raddr = rd_addr;
                rtype = rd_type;
            end
            // reference copy follows the store the testbench issued
            if (fire_wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (cur_wstrb[b]) begin
                        shadow[cur_addr[15:2]][8 * b +: 8] = cur_wdata[8 * b +: 8];
                    end
                end
            end
            @(posedge clk);
            #5;
            rd_rdy = 1'b0;
            wr_rdy = 1'b0;
            ret_valid = 1'b0;
            ret_last = 1'b0;
            if (fire_wr) begin
                lane = wr_addr[3:2];
                for (int b = 0; b < 4; b++) begin
                    if (wr_wstrb[lane * 4 + b]) begin
                        mem[wr_addr[15:2]][8 * b +: 8] = wr_data[lane * 32 + 8 * b +: 8];
                    end
                end
            end
            if (fire_rd) begin
                pend = 1'b1;
                delay = $urandom % 4;
            end else if (pend && delay > 0) begin
                delay--;
            end else if (pend) begin
                pend = 1'b0;
                ret_valid = 1'b1;
                ret_last = 1'b1;
                if (rtype == TYPE_LINE) begin
                    for (int w = 0; w < 4; w++) begin
                        ret_data[32 * w +: 32] = mem[{raddr[15:4], w[1:0]}];
                    end
                end else begin
                    ret_data = {96'b0, mem[raddr[15:2]]};
                end
            end
            rd_rdy = rd_req && !fire_rd && !pend && ($urandom % 3 == 0);
            wr_rdy = wr_req && !fire_wr && !wr_block && ($urandom % 3 == 0);
        end
    end

    // starts just after a rising edge and returns on one
    task automatic run_req(input logic w, input logic u, input logic [19:0] t,
                           input logic [7:0] idx, input logic [3:0] off,
                           input logic [3:0] strb, input logic [31:0] d, input logic fl);
        logic saw_ok;
        saw_ok = 1'b0;
        #5;
        cur_op = w;
        cur_uncache = u;
        cur_addr = {t, idx, off[3:2], 2'b00};
        cur_wstrb = strb;
        cur_wdata = d;
        wr_block = fl;
        {valid, op, uncache, tag, index, offset, wstrb, wdata} = {1'b1, w, u, t, idx, off, strb, d};
        do @(negedge clk); while (!addr_ok);
        exp_word = expected_word(cur_addr);
        @(posedge clk);
        #5;
        valid = 1'b0;
        if (fl) begin
            do @(negedge clk); while (!wr_req);
            @(posedge clk);
            #5;
            flush_i = 1'b1;
            @(negedge clk);
            saw_ok = data_ok;
            @(posedge clk);
            #5;
            flush_i = 1'b0;
            wr_block = 1'b0;
            repeat (3) begin
                @(negedge clk);
                saw_ok = saw_ok | data_ok;
            end
            if (saw_ok || !addr_ok) begin
                $display("error at %0t: flushed write answered or cache not idle", $time);
                tb_errors++;
            end
        end else begin
            do @(negedge clk); while (!data_ok);
        end
        @(posedge clk);
    endtask

    task automatic expect_count(input int got, input int want, input string what);
        if (got != want) begin
            $display("error at %0t: %0d %s requests, expected %0d", $time, got, what, want);
            tb_errors++;
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (chk_errors + tb_errors != errs_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    initial begin
        int base, r0, w0;
        logic [3:0] strb;
        void'($urandom(32'hd440_1c9e));
        for (int i = 0; i < MEM_DEPTH; i++) begin
            mem[i] = (i * 32'h9e37_79b1) ^ {i[7:0], i[13:0], 10'h2a5};
            shadow[i] = mem[i];
        end
        {valid, op, uncache, flush_i, tag, index, offset, wstrb, wdata} = '0;
        {rd_rdy, ret_valid, ret_last, ret_data, wr_rdy} = '0;
        {cur_op, cur_uncache, cur_addr, cur_wstrb, cur_wdata, exp_word, wr_block} = '0;
        tb_errors = 0;
        tests_failed = 0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #5 rst = 1'b0;
        do @(negedge clk); while (!addr_ok);
        @(posedge clk);

        base = chk_errors + tb_errors;
        r0 = rd_fires;
        run_req(0, 0, 20'h1, 8'h20, 4'h4, 4'h0, 0, 0);
        expect_count(rd_fires - r0, 1, "line read");
        end_test("cold_read", base);

        base = chk_errors + tb_errors;
        r0 = rd_fires;
        run_req(0, 0, 20'h1, 8'h20, 4'h8, 4'h0, 0, 0);
        expect_count(rd_fires - r0, 0, "read");
        end_test("reread", base);

        base = chk_errors + tb_errors;
        w0 = wr_fires;
        run_req(1, 0, 20'h1, 8'h20, 4'h8, 4'b0110, 32'hdead_beef, 0);
        run_req(0, 0, 20'h1, 8'h20, 4'h8, 4'h0, 0, 0);
        run_req(1, 0, 20'h2, 8'h21, 4'hc, 4'b1001, 32'h1234_5678, 0);
        run_req(0, 0, 20'h2, 8'h21, 4'hc, 4'h0, 0, 0);
        expect_count(wr_fires - w0, 2, "write");
        end_test("write_through", base);

        base = chk_errors + tb_errors;
        r0 = rd_fires;
        repeat (3) run_req(0, 1, 20'h3, 8'h22, 4'h4, 4'h0, 0, 0);
        run_req(0, 1, 20'h1, 8'h20, 4'h8, 4'h0, 0, 0);
        expect_count(rd_fires - r0, 4, "word read");
        end_test("uncached_read", base);

        base = chk_errors + tb_errors;
        w0 = wr_fires;
        run_req(1, 0, 20'h1, 8'h20, 4'h0, 4'b1111, 32'h0bad_f00d, 1);
        run_req(0, 0, 20'h1, 8'h20, 4'h0, 4'h0, 0, 0);
        expect_count(wr_fires - w0, 0, "write");
        end_test("flush", base);

        base = chk_errors + tb_errors;
        for (int n = 0; n < N_RAND; n++) begin
            strb = 4'($urandom % 15 + 1);
            run_req($urandom % 2, $urandom % 4 == 0, 20'($urandom % 16),
                    8'($urandom % 4 + 8), 4'($urandom % 4 * 4), strb, $urandom, 0);
        end
        end_test("random_mix", base);

        $display("tests failed %0d of 6, errors %0d", tests_failed, chk_errors + tb_errors);
        if (chk_errors + tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- tb.f
common/dcache_pkg.sv
rtl/bram.sv
rtl/lfsr.sv
rtl/dcache/dcache_way.sv
rtl/dcache/dcache_ctrl.sv
rtl/dcache/dcache_top.sv
verification/dcache_checker.sv
verification/dcache_tb.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - common/dcache_pkg.sv
  - rtl/bram.sv
  - rtl/lfsr.sv
  - rtl/dcache/dcache_way.sv
  - rtl/dcache/dcache_ctrl.sv
  - rtl/dcache/dcache_top.sv
  - target: test
    files:
      - verification/dcache_checker.sv
      - verification/dcache_tb.sv
